/* pic_controller.f */
+incdir+dv
hdl/pic_pkg.sv
hdl/pic_command_decoder.sv
hdl/pic_priority_service.sv
hdl/pic_ack_sequencer.sv
hdl/pic_controller.sv
dv/pic_controller_tb.sv

/* Makefile */
# Verilator build and run of the interrupt controller testbench

SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = pic_controller_tb
FILELIST = pic_controller.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)

/* dv/pic_tb_tasks.svh */
// Bus write, register read and INTA tasks for the controller testbench
// Value checks, per-test reporting and the expected-value helpers

`ifndef PIC_TB_TASKS_SVH
`define PIC_TB_TASKS_SVH

function automatic logic [7:0] level_bit(input int level);
    return 8'h01 << level;
endfunction

// Level 0 wins
function automatic int highest_level(input logic [7:0] bits);
    for (int i = 0; i < 8; i++) begin
        if (bits[i]) begin
            return i;
        end
    end
    return -1;
endfunction

function automatic logic [7:0] expected_vector(input logic [4:0] vector_base, input int level);
    return 8'(vector_base * 8 + level);
endfunction

function automatic logic [7:0] poll_word(input logic [7:0] pending);
    int level;
    level = highest_level(pending);
    if (level < 0) begin
        return 8'h00;
    end
    return 8'h80 | 8'(level);
endfunction

task automatic check_value(input string name, input logic [7:0] actual,
                           input logic [7:0] expected);
    check_count++;
    assert (actual === expected) else begin
        $display("MISMATCH %s: got %02h, expected %02h", name, actual, expected);
        error_count++;
    end
endtask

task automatic finish_test(input string name, input int errors_before);
    test_count++;
    if (error_count == errors_before) begin
        passed_count++;
        $display("test %0d %s: passed", test_count, name);
    end else begin
        $display("test %0d %s: failed with %0d errors", test_count, name,
                 error_count - errors_before);
    end
endtask

task automatic write_command(input logic a0, input logic [7:0] data);
    @(negedge clock);
    bus.write = 1'b1;
    bus.a0    = a0;
    bus.data  = data;
    @(negedge clock);
    bus.write = 1'b0;
endtask

task automatic read_register(input logic a0, output logic [7:0] data);
    int waited;
    @(negedge clock);
    bus.read = 1'b1;
    bus.a0   = a0;
    @(negedge clock);
    bus.read = 1'b0;
    waited   = 0;
    while (!read_data_valid && waited < 4) begin
        @(negedge clock);
        waited++;
    end
    if (!read_data_valid) begin
        $display("register read with a0=%0d returned no data", a0);
        error_count++;
    end
    data = read_data;
endtask

task automatic wait_for_interrupt();
    int waited;
    waited = 0;
    while (!interrupt_to_cpu && waited < 8) begin
        @(negedge clock);
        waited++;
    end
    if (!interrupt_to_cpu) begin
        $display("interrupt_to_cpu did not rise within %0d cycles", waited);
        error_count++;
    end
endtask

// Two INTA pulses, the vector comes with the second
task automatic acknowledge_interrupt(input logic [7:0] expected);
    int waited;
    @(negedge clock);
    interrupt_acknowledge_n = 1'b0;
    @(negedge clock);
    check_value("interrupt_to_cpu", 8'(interrupt_to_cpu), 8'h00);
    interrupt_acknowledge_n = 1'b1;
    @(negedge clock);
    interrupt_acknowledge_n = 1'b0;
    waited = 0;
    do begin
        @(negedge clock);
        waited++;
    end while (!read_data_valid && waited < 4);
    if (!read_data_valid) begin
        $display("no vector returned on the second INTA pulse");
        error_count++;
    end
    check_value("read_data vector", read_data, expected);
    // Vector held while INTA stays low
    @(negedge clock);
    check_value("read_data_valid", 8'(read_data_valid), 8'h01);
    check_value("read_data vector hold", read_data, expected);
    interrupt_acknowledge_n = 1'b1;
    @(negedge clock);
endtask

task automatic init_controller(input logic level_mode, input logic auto_eoi,
                               input logic single, input logic [4:0] vector_base);
    write_command(1'b0, {4'b0001, level_mode, 1'b0, single, 1'b1});
    write_command(1'b1, {vector_base, 3'b000});
    if (!single) begin
        // ICW3 accepted and dropped
        write_command(1'b1, 8'h00);
    end
    write_command(1'b1, {6'b000000, auto_eoi, 1'b1});
endtask

`endif

/* dv/pic_controller_tb.sv */
// Testbench for the single mode 8086 interrupt controller
// Clock, reset, DUT, the test sequence, protocol assertions and reporting

`timescale 1ns/1ns

module pic_controller_tb;

    localparam int TIMEOUT_CYCLES = 4000;

    logic              clock;
    logic              reset;
    pic_pkg::pic_bus_t bus;
    pic_pkg::irq_vec_t interrupt_request;
    logic              interrupt_acknowledge_n;
    logic              interrupt_to_cpu;
    logic [7:0]        read_data;
    logic              read_data_valid;

    integer     seed = 32'hc1c3;
    int         error_count = 0;
    int         check_count = 0;
    int         test_count = 0;
    int         passed_count = 0;
    int         cycle_count = 0;
    logic       quiet_window;
    logic       read_strobe;
    logic [7:0] value;
    logic [7:0] rand_mask;
    logic [7:0] pattern;
    logic [4:0] base;
    int         level;
    int         start;

    `include "pic_tb_tasks.svh"

    pic_controller DUT (
        .clock                   (clock),
        .reset                   (reset),
        .bus                     (bus),
        .interrupt_request       (interrupt_request),
        .interrupt_acknowledge_n (interrupt_acknowledge_n),
        .interrupt_to_cpu        (interrupt_to_cpu),
        .read_data               (read_data),
        .read_data_valid         (read_data_valid)
    );

    initial clock = 1'b0;
    always #2 clock = ~clock;

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("run stopped after %0d cycles without finishing", cycle_count);
            $display("TEST FAILED");
            $finish;
        end
    end

    assign read_strobe = bus.read;

    // Only masked or nested-out requests are raised in this window
    assert property (@(posedge clock) disable iff (reset)
        quiet_window |-> !interrupt_to_cpu)
        else begin
            $display("interrupt_to_cpu rose while every raised request was blocked");
            error_count++;
        end

    assert property (@(posedge clock) disable iff (reset)
        (!$past(read_strobe) && interrupt_acknowledge_n && $past(interrupt_acknowledge_n))
        |-> !read_data_valid)
        else begin
            $display("read_data_valid high with no read strobe and no acknowledge");
            error_count++;
        end

    initial begin
        bus                     = '0;
        interrupt_request       = '0;
        interrupt_acknowledge_n = 1'b1;
        quiet_window            = 1'b0;
        reset                   = 1'b1;
        repeat (8) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        start = error_count;
        read_register(1'b1, value);
        check_value("read_data mask after reset", value, 8'hff);
        base = 5'($random(seed));
        init_controller(1'b0, 1'b0, 1'b1, base);
        rand_mask = 8'($random(seed));
        write_command(1'b1, rand_mask);
        read_register(1'b1, value);
        check_value("read_data mask", value, rand_mask);
        finish_test("mask readback", start);

        start = error_count;
        level = $random(seed) & 7;
        init_controller(1'b0, 1'b0, 1'b1, base);
        write_command(1'b1, ~level_bit(level));
        @(negedge clock);
        interrupt_request = level_bit(level);
        wait_for_interrupt();
        acknowledge_interrupt(expected_vector(base, level));
        write_command(1'b0, 8'h0a);
        read_register(1'b0, value);
        check_value("read_data irr", value, 8'h00);
        write_command(1'b0, 8'h0b);
        read_register(1'b0, value);
        check_value("read_data isr", value, level_bit(level));
        interrupt_request = '0;
        finish_test("acknowledge vector", start);

        start = error_count;
        init_controller(1'b0, 1'b0, 1'b1, base);
        write_command(1'b1, 8'h00);
        write_command(1'b0, 8'h0b);
        @(negedge clock);
        interrupt_request = level_bit(5);
        wait_for_interrupt();
        acknowledge_interrupt(expected_vector(base, 5));
        quiet_window      = 1'b1;
        interrupt_request = level_bit(5) | level_bit(6);
        repeat (6) @(negedge clock);
        quiet_window      = 1'b0;
        interrupt_request = level_bit(2) | level_bit(5) | level_bit(6);
        wait_for_interrupt();
        acknowledge_interrupt(expected_vector(base, 2));
        write_command(1'b0, 8'h65);
        read_register(1'b0, value);
        check_value("read_data isr", value, level_bit(2));
        write_command(1'b0, 8'h20);
        read_register(1'b0, value);
        check_value("read_data isr", value, 8'h00);
        // Level 6 is no longer nested out
        wait_for_interrupt();
        acknowledge_interrupt(expected_vector(base, 6));
        write_command(1'b0, 8'h20);
        interrupt_request = '0;
        finish_test("fully nested priority", start);

        start = error_count;
        level = $random(seed) & 7;
        init_controller(1'b0, 1'b1, 1'b0, base);
        rand_mask = 8'($random(seed));
        write_command(1'b1, rand_mask & ~level_bit(level));
        write_command(1'b0, 8'h0b);
        @(negedge clock);
        interrupt_request = level_bit(level);
        wait_for_interrupt();
        acknowledge_interrupt(expected_vector(base, level));
        read_register(1'b0, value);
        check_value("read_data isr", value, 8'h00);
        interrupt_request = '0;
        finish_test("automatic eoi", start);

        start = error_count;
        init_controller(1'b0, 1'b0, 1'b1, base);
        write_command(1'b1, 8'h00);
        pattern = 8'($random(seed)) | 8'h80;
        @(negedge clock);
        interrupt_request = pattern;
        wait_for_interrupt();
        write_command(1'b0, 8'h0c);
        read_register(1'b0, value);
        check_value("read_data poll", value, poll_word(pattern));
        check_value("interrupt_to_cpu", 8'(interrupt_to_cpu), 8'h00);
        write_command(1'b1, 8'hff);
        write_command(1'b0, 8'h0c);
        read_register(1'b0, value);
        check_value("read_data poll", value, poll_word(8'h00));
        interrupt_request = '0;
        finish_test("poll", start);

        start = error_count;
        level = $random(seed) & 7;
        init_controller(1'b0, 1'b0, 1'b1, base);
        write_command(1'b1, level_bit(level));
        @(negedge clock);
        quiet_window      = 1'b1;
        interrupt_request = level_bit(level);
        repeat (8) @(negedge clock);
        quiet_window      = 1'b0;
        interrupt_request = '0;
        // Edge mode, line held high
        init_controller(1'b0, 1'b0, 1'b1, base);
        write_command(1'b1, 8'h00);
        @(negedge clock);
        interrupt_request = level_bit(level);
        wait_for_interrupt();
        acknowledge_interrupt(expected_vector(base, level));
        write_command(1'b0, 8'h20);
        quiet_window = 1'b1;
        repeat (8) @(negedge clock);
        quiet_window      = 1'b0;
        interrupt_request = '0;
        // Level mode requests again after each eoi
        init_controller(1'b1, 1'b0, 1'b1, base);
        write_command(1'b1, 8'h00);
        @(negedge clock);
        interrupt_request = level_bit(level);
        wait_for_interrupt();
        acknowledge_interrupt(expected_vector(base, level));
        write_command(1'b0, 8'h20);
        wait_for_interrupt();
        acknowledge_interrupt(expected_vector(base, level));
        write_command(1'b0, 8'h20);
        interrupt_request = '0;
        finish_test("mask and trigger mode", start);

        $display("checks %0d, errors %0d, tests passed %0d of %0d",
                 check_count, error_count, passed_count, test_count);
        if (error_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* hdl/pic_controller.sv */
// Top level of the single mode 8086 interrupt controller
// Connects the command decoder, priority service and acknowledge sequencer

`timescale 1ns/1ns

module pic_controller (
    input  logic                clock,
    input  logic                reset,
    input  pic_pkg::pic_bus_t   bus,
    input  pic_pkg::irq_vec_t   interrupt_request,
    input  logic                interrupt_acknowledge_n,
    output logic                interrupt_to_cpu,
    output logic [7:0]          read_data,
    output logic                read_data_valid
);

    pic_pkg::pic_cfg_t cfg;
    pic_pkg::irq_vec_t mask;
    pic_pkg::eoi_cmd_t eoi;
    logic              init;
    logic              poll_cmd;
    pic_pkg::irq_vec_t irr;
    pic_pkg::irq_vec_t isr;
    logic              request_pending;
    pic_pkg::irq_id_t  service_level;
    logic              take;
    logic              service_done;

    pic_command_decoder u_command_decoder (
        .clock    (clock),
        .reset    (reset),
        .bus      (bus),
        .cfg      (cfg),
        .mask     (mask),
        .eoi      (eoi),
        .init     (init),
        .poll_cmd (poll_cmd)
    );

    pic_priority_service u_priority_service (
        .clock             (clock),
        .reset             (reset),
        .interrupt_request (interrupt_request),
        .cfg               (cfg),
        .mask              (mask),
        .eoi               (eoi),
        .init              (init),
        .take              (take),
        .service_done      (service_done),
        .irr               (irr),
        .isr               (isr),
        .request_pending   (request_pending),
        .service_level     (service_level)
    );

    pic_ack_sequencer u_ack_sequencer (
        .clock                   (clock),
        .reset                   (reset),
        .bus                     (bus),
        .interrupt_acknowledge_n (interrupt_acknowledge_n),
        .cfg                     (cfg),
        .mask                    (mask),
        .irr                     (irr),
        .isr                     (isr),
        .request_pending         (request_pending),
        .service_level           (service_level),
        .init                    (init),
        .poll_cmd                (poll_cmd),
        .take                    (take),
        .service_done            (service_done),
        .interrupt_to_cpu        (interrupt_to_cpu),
        .read_data               (read_data),
        .read_data_valid         (read_data_valid)
    );

endmodule

/* hdl/pic_ack_sequencer.sv */
// CPU facing side of the interrupt controller
// Two pulse 8086 acknowledge and poll sequencing, INT output,
// and the read data multiplexer for vector, poll word and registers

`timescale 1ns/1ns

module pic_ack_sequencer (
    input  logic                clock,
    input  logic                reset,
    input  pic_pkg::pic_bus_t   bus,
    input  logic                interrupt_acknowledge_n,
    input  pic_pkg::pic_cfg_t   cfg,
    input  pic_pkg::irq_vec_t   mask,
    input  pic_pkg::irq_vec_t   irr,
    input  pic_pkg::irq_vec_t   isr,
    input  logic                request_pending,
    input  pic_pkg::irq_id_t    service_level,
    input  logic                init,
    input  logic                poll_cmd,
    output logic                take,
    output logic                service_done,
    output logic                interrupt_to_cpu,
    output logic [7:0]          read_data,
    output logic                read_data_valid
);

    typedef enum logic [1:0] {
        SEQ_READY,
        SEQ_ACK1,
        SEQ_ACK2,
        SEQ_POLL
    } seq_state_t;

    seq_state_t seq_state;
    seq_state_t next_state;
    logic       prev_ack_n;
    logic       ack_fall;
    logic       ack_rise;
    logic       poll_hit;
    logic [7:0] next_read_data;
    logic       next_read_valid;

    always_ff @(posedge clock) begin
        if (reset) begin
            prev_ack_n <= 1'b1;
        end else begin
            prev_ack_n <= interrupt_acknowledge_n;
        end
    end

    assign ack_fall = prev_ack_n && !interrupt_acknowledge_n;
    assign ack_rise = !prev_ack_n && interrupt_acknowledge_n;

    always_comb begin
        next_state = seq_state;
        case (seq_state)
            SEQ_READY: begin
                if (poll_cmd) begin
                    next_state = SEQ_POLL;
                end else if (ack_fall) begin
                    next_state = SEQ_ACK1;
                end
            end
            SEQ_ACK1: begin
                // Second INTA pulse
                if (ack_fall) begin
                    next_state = SEQ_ACK2;
                end
            end
            SEQ_ACK2: begin
                if (ack_rise) begin
                    next_state = SEQ_READY;
                end
            end
            SEQ_POLL: begin
                if (bus.read) begin
                    next_state = SEQ_READY;
                end
            end
            default: begin
                next_state = SEQ_READY;
            end
        endcase
        if (init) begin
            next_state = SEQ_READY;
        end
    end

    assign take = (seq_state == SEQ_READY) && (poll_cmd || ack_fall)
                  && request_pending && !init;
    assign service_done = (seq_state == SEQ_ACK2) && ack_rise && !init;

    // Vector during the second pulse, otherwise the addressed register
    always_comb begin
        next_read_valid = 1'b0;
        next_read_data  = read_data;
        if (next_state == SEQ_ACK2) begin
            next_read_valid = 1'b1;
            next_read_data  = {cfg.vector_base, service_level};
        end else if (bus.read) begin
            next_read_valid = 1'b1;
            if (seq_state == SEQ_POLL) begin
                next_read_data = poll_hit ? {1'b1, 4'b0000, service_level} : 8'h00;
            end else if (bus.a0) begin
                next_read_data = mask;
            end else if (cfg.read_isr) begin
                next_read_data = isr;
            end else begin
                next_read_data = irr;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            seq_state        <= SEQ_READY;
            poll_hit         <= 1'b0;
            interrupt_to_cpu <= 1'b0;
            read_data_valid  <= 1'b0;
        end else begin
            seq_state       <= next_state;
            read_data_valid <= next_read_valid;
            if (init) begin
                poll_hit <= 1'b0;
            end else if ((seq_state == SEQ_READY) && poll_cmd) begin
                poll_hit <= take;
            end
            // INT held low through the acknowledge, follows pending when idle
            if (init || take) begin
                interrupt_to_cpu <= 1'b0;
            end else if (seq_state == SEQ_READY) begin
                interrupt_to_cpu <= request_pending;
            end
        end
    end

    always_ff @(posedge clock) begin
        read_data <= next_read_data;
    end

    // Register reads are single cycle; only the vector is held
    assert property (@(posedge clock) disable iff (reset)
        (read_data_valid && (seq_state != SEQ_ACK2))
        |=> (!read_data_valid || (seq_state == SEQ_ACK2)));

endmodule

/* hdl/pic_priority_service.sv */
// Request and service side of the interrupt controller
// Edge or level request detection, IRR and ISR registers,
// fixed fully nested priority resolution and end of interrupt handling

`timescale 1ns/1ns

module pic_priority_service (
    input  logic                clock,
    input  logic                reset,
    input  pic_pkg::irq_vec_t   interrupt_request,
    input  pic_pkg::pic_cfg_t   cfg,
    input  pic_pkg::irq_vec_t   mask,
    input  pic_pkg::eoi_cmd_t   eoi,
    input  logic                init,
    input  logic                take,
    input  logic                service_done,
    output pic_pkg::irq_vec_t   irr,
    output pic_pkg::irq_vec_t   isr,
    output logic                request_pending,
    output pic_pkg::irq_id_t    service_level
);

    pic_pkg::irq_vec_t prev_request;
    pic_pkg::irq_vec_t edge_request;
    pic_pkg::irq_vec_t masked_irr;
    pic_pkg::irq_vec_t isr_top;
    pic_pkg::irq_vec_t above_isr;
    pic_pkg::irq_vec_t eligible;
    pic_pkg::irq_id_t  winner;
    pic_pkg::irq_vec_t take_bit;
    pic_pkg::irq_vec_t eoi_clear;
    pic_pkg::irq_vec_t auto_clear;

    always_ff @(posedge clock) begin
        if (reset) begin
            prev_request <= '0;
        end else begin
            prev_request <= interrupt_request;
        end
    end

    assign edge_request = interrupt_request & ~prev_request;

    // Highest priority level currently in service, one-hot
    assign isr_top   = isr & (~isr + 1'b1);
    // Levels allowed to nest above it
    assign above_isr = (isr == '0) ? '1 : (isr_top - 1'b1);

    assign masked_irr      = irr & ~mask;
    assign eligible        = masked_irr & above_isr;
    assign request_pending = eligible != '0;
    assign winner          = pic_pkg::bit_to_level(eligible);

    assign take_bit = take ? pic_pkg::level_to_bit(winner) : '0;

    always_comb begin
        if (!eoi.valid) begin
            eoi_clear = '0;
        end else if (eoi.specific) begin
            eoi_clear = pic_pkg::level_to_bit(eoi.level);
        end else begin
            eoi_clear = isr_top;
        end
    end

    assign auto_clear = (service_done && cfg.auto_eoi)
                        ? pic_pkg::level_to_bit(service_level) : '0;

    // Level mode tracks the line, edge mode latches until taken
    always_ff @(posedge clock) begin
        if (reset || init) begin
            irr <= '0;
        end else if (cfg.level_triggered) begin
            irr <= interrupt_request & ~take_bit;
        end else begin
            irr <= (irr | edge_request) & ~take_bit;
        end
    end

    always_ff @(posedge clock) begin
        if (reset || init) begin
            isr <= '0;
        end else begin
            isr <= (isr & ~(eoi_clear | auto_clear)) | take_bit;
        end
    end

    always_ff @(posedge clock) begin
        if (take) begin
            service_level <= winner;
        end
    end

    // The sequencer only takes a request that the resolver offers
    assert property (@(posedge clock) disable iff (reset)
        take |-> request_pending);

endmodule

/* hdl/pic_command_decoder.sv */
// Command write side of the interrupt controller
// Sequences ICW1, ICW2, ICW3 and ICW4, then decodes OCW1, OCW2 and OCW3
// Holds configuration and mask, emits eoi, init and poll pulses

`timescale 1ns/1ns

module pic_command_decoder (
    input  logic                clock,
    input  logic                reset,
    input  pic_pkg::pic_bus_t   bus,
    output pic_pkg::pic_cfg_t   cfg,
    output pic_pkg::irq_vec_t   mask,
    output pic_pkg::eoi_cmd_t   eoi,
    output logic                init,
    output logic                poll_cmd
);

    typedef enum logic [1:0] {
        CMD_READY,
        CMD_ICW2,
        CMD_ICW3,
        CMD_ICW4
    } cmd_state_t;

    cmd_state_t         cmd_state;
    pic_pkg::cmd_word_u word;
    logic               single_mode;
    logic               icw4_needed;
    logic               write_icw1;
    logic               write_init_word;
    logic               write_ocw1;
    logic               write_ocw2;
    logic               write_ocw3;
    logic               eoi_supported;

    assign word.raw = bus.data;

    // ICW1 is recognised in any state
    assign write_icw1      = bus.write && !bus.a0 && word.icw1.select;
    assign write_init_word = bus.write && bus.a0 && (cmd_state != CMD_READY);
    assign write_ocw1      = bus.write && bus.a0 && (cmd_state == CMD_READY);
    assign write_ocw2      = bus.write && !bus.a0 && (cmd_state == CMD_READY)
                             && (word.ocw2.select == 2'b00);
    assign write_ocw3      = bus.write && !bus.a0 && (cmd_state == CMD_READY)
                             && (word.ocw3.select == 2'b01);

    assign eoi_supported = (word.ocw2.eoi_code == pic_pkg::OCW2_NONSPECIFIC_EOI)
                           || (word.ocw2.eoi_code == pic_pkg::OCW2_SPECIFIC_EOI);

    // Initialization sequence, ICW3 only consumed
    always_ff @(posedge clock) begin
        if (reset) begin
            cmd_state   <= CMD_READY;
            single_mode <= 1'b1;
            icw4_needed <= 1'b0;
        end else if (write_icw1) begin
            cmd_state   <= CMD_ICW2;
            single_mode <= word.icw1.sngl;
            icw4_needed <= word.icw1.ic4;
        end else if (write_init_word) begin
            case (cmd_state)
                CMD_ICW2: begin
                    if (!single_mode) begin
                        cmd_state <= CMD_ICW3;
                    end else if (icw4_needed) begin
                        cmd_state <= CMD_ICW4;
                    end else begin
                        cmd_state <= CMD_READY;
                    end
                end
                CMD_ICW3: begin
                    cmd_state <= icw4_needed ? CMD_ICW4 : CMD_READY;
                end
                default: begin
                    cmd_state <= CMD_READY;
                end
            endcase
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            cfg <= '0;
        end else if (write_icw1) begin
            cfg.level_triggered <= word.icw1.ltim;
            cfg.auto_eoi        <= 1'b0;
            cfg.vector_base     <= '0;
            cfg.read_isr        <= 1'b0;
        end else if (write_init_word && (cmd_state == CMD_ICW2)) begin
            cfg.vector_base <= word.raw[7:3];
        end else if (write_init_word && (cmd_state == CMD_ICW4)) begin
            cfg.auto_eoi <= word.raw[1];
        end else if (write_ocw3 && word.ocw3.read_enable) begin
            cfg.read_isr <= word.ocw3.read_isr;
        end
    end

    // Everything masked until software says otherwise
    always_ff @(posedge clock) begin
        if (reset || write_icw1) begin
            mask <= '1;
        end else if (write_ocw1) begin
            mask <= word.raw;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            eoi      <= '0;
            init     <= 1'b0;
            poll_cmd <= 1'b0;
        end else begin
            init         <= write_icw1;
            poll_cmd     <= write_ocw3 && word.ocw3.poll;
            eoi.valid    <= write_ocw2 && eoi_supported;
            eoi.specific <= word.ocw2.eoi_code == pic_pkg::OCW2_SPECIFIC_EOI;
            eoi.level    <= word.ocw2.level;
        end
    end

    // Operation commands only once initialization has finished
    assert property (@(posedge clock) disable iff (reset)
        (eoi.valid || poll_cmd) |-> (cmd_state == CMD_READY));

endmodule

/* hdl/pic_pkg.sv */
// Shared definitions for the interrupt controller
// Level counts, bus cycle and configuration structs, command word views
// and conversions between level numbers and one-hot level vectors

package pic_pkg;

    localparam int IRQ_COUNT    = 8;
    localparam int IRQ_ID_WIDTH = 3;

    typedef logic [IRQ_COUNT-1:0]    irq_vec_t;
    typedef logic [IRQ_ID_WIDTH-1:0] irq_id_t;

    // One CPU bus cycle, strobes last a single clock
    typedef struct packed {
        logic       write;
        logic       read;
        logic       a0;
        logic [7:0] data;
    } pic_bus_t;

    // ICW1 layout, address bits and ADI unused in 8086 mode
    typedef struct packed {
        logic [2:0] reserved_hi;
        logic       select;
        logic       ltim;
        logic       reserved_adi;
        logic       sngl;
        logic       ic4;
    } icw1_t;

    typedef struct packed {
        logic [2:0] eoi_code;
        logic [1:0] select;
        irq_id_t    level;
    } ocw2_t;

    // Special mask bits D6-D5 are not supported
    typedef struct packed {
        logic       reserved_d7;
        logic [1:0] reserved_smm;
        logic [1:0] select;
        logic       poll;
        logic       read_enable;
        logic       read_isr;
    } ocw3_t;

    typedef union packed {
        icw1_t      icw1;
        ocw2_t      ocw2;
        ocw3_t      ocw3;
        logic [7:0] raw;
    } cmd_word_u;

    typedef struct packed {
        logic       level_triggered;
        logic       auto_eoi;
        logic [4:0] vector_base;
        logic       read_isr;
    } pic_cfg_t;

    typedef struct packed {
        logic    valid;
        logic    specific;
        irq_id_t level;
    } eoi_cmd_t;

    localparam logic [2:0] OCW2_NONSPECIFIC_EOI = 3'b001;
    localparam logic [2:0] OCW2_SPECIFIC_EOI    = 3'b011;

    function automatic irq_vec_t level_to_bit(input irq_id_t level);
        return irq_vec_t'(1) << level;
    endfunction

    // Lowest set bit wins, level 0 is the highest priority
    function automatic irq_id_t bit_to_level(input irq_vec_t bits);
        irq_id_t level;
        level = '0;
        for (int i = IRQ_COUNT - 1; i >= 0; i--) begin
            if (bits[i]) begin
                level = irq_id_t'(i);
            end
        end
        return level;
    endfunction

endpackage
